// ==== logic/cmd_holding_reg.sv ====
// one-entry command buffer in front of the Wishbone master
// holds a command with stable fields until the master consumes it

`timescale 1ns/1ns

module cmd_holding_reg (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      cmd_v_i,
  output logic                      cmd_ready_o,
  input  wb_bridge_pkg::msg_type_t  cmd_type_i,
  input  wb_bridge_pkg::msg_size_t  cmd_size_i,
  input  wb_bridge_pkg::addr_t      cmd_addr_i,
  input  wb_bridge_pkg::data_t      cmd_data_i,
  output logic                      hold_v_o,
  output wb_bridge_pkg::msg_type_t  hold_type_o,
  output wb_bridge_pkg::msg_size_t  hold_size_o,
  output wb_bridge_pkg::addr_t      hold_addr_o,
  output wb_bridge_pkg::data_t      hold_data_o,
  input  logic                      hold_consume_i
);

  logic full_r;
  logic accept;

  assign accept      = cmd_v_i & ~full_r;
  assign cmd_ready_o = ~full_r;
  assign hold_v_o    = full_r;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_r <= 1'b0;
    end else if (accept) begin
      full_r <= 1'b1;
    end else if (hold_consume_i) begin
      full_r <= 1'b0;
    end
  end

  // payload, only meaningful while full
  always_ff @(posedge clk_i) begin
    if (accept) begin
      hold_type_o <= cmd_type_i;
      hold_size_o <= cmd_size_i;
      hold_addr_o <= cmd_addr_i;
      hold_data_o <= cmd_data_i;
    end
  end

  // master may only consume a command it was offered
  a_consume_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    hold_consume_i |-> full_r)
    else $error("consume while holding register empty");

endmodule

// ==== logic/mem_wb_master.sv ====
// Wishbone classic master for single-beat uncached commands
// takes a held command, runs one bus cycle and pushes the response on the ack
// cycle start waits for a free response FIFO entry

`timescale 1ns/1ns
`include "wb_bridge_params.svh"

module mem_wb_master (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      hold_v_i,
  input  wb_bridge_pkg::msg_type_t  hold_type_i,
  input  wb_bridge_pkg::msg_size_t  hold_size_i,
  input  wb_bridge_pkg::addr_t      hold_addr_i,
  input  wb_bridge_pkg::data_t      hold_data_i,
  output logic                      hold_consume_o,
  input  logic                      fifo_space_i,
  output logic                      push_o,
  output wb_bridge_pkg::rsp_hdr_t   push_hdr_o,
  output wb_bridge_pkg::data_t      push_data_o,
  output logic                      wb_cyc_o,
  output logic                      wb_stb_o,
  output logic                      wb_we_o,
  output wb_bridge_pkg::wb_adr_t    wb_adr_o,
  output wb_bridge_pkg::sel_t       wb_sel_o,
  output wb_bridge_pkg::data_t      wb_dat_o,
  input  wb_bridge_pkg::data_t      wb_dat_i,
  input  logic                      wb_ack_i
);

  typedef enum logic {
    ST_IDLE,
    ST_WAIT_ACK
  } state_e;

  state_e state_r;
  state_e state_n;
  logic   cyc_r;
  logic   cyc_n;
  logic   ack_seen;

  wb_bridge_pkg::data_t rd_packed;

  // bus fields follow the held command directly, it is stable until consume
  assign wb_we_o  = (hold_type_i == wb_bridge_pkg::MSG_UC_WR);
  assign wb_adr_o = hold_addr_i[`WB_ADDR_W-1:2];
  assign wb_dat_o = hold_data_i;

  // low-lane byte selects from the size
  always_comb begin
    case (hold_size_i)
      wb_bridge_pkg::SIZE_1: wb_sel_o = 4'b0001;
      wb_bridge_pkg::SIZE_2: wb_sel_o = 4'b0011;
      default:               wb_sel_o = 4'b1111;
    endcase
  end

  // narrow read data repeated over all lanes
  always_comb begin
    case (hold_size_i)
      wb_bridge_pkg::SIZE_1: rd_packed = {4{wb_dat_i[7:0]}};
      wb_bridge_pkg::SIZE_2: rd_packed = {2{wb_dat_i[15:0]}};
      default:               rd_packed = wb_dat_i;
    endcase
  end

  assign ack_seen       = (state_r == ST_WAIT_ACK) & wb_ack_i;
  assign hold_consume_o = ack_seen;
  assign push_o         = ack_seen;
  assign push_hdr_o     = {hold_type_i, hold_size_i, hold_addr_i};
  // writes answer with zero data
  assign push_data_o    = wb_we_o ? '0 : rd_packed;

  always_comb begin
    state_n = state_r;
    cyc_n   = 1'b0;
    case (state_r)
      ST_IDLE: begin
        cyc_n = hold_v_i & fifo_space_i;
        if (cyc_n) begin
          state_n = ST_WAIT_ACK;
        end
      end
      ST_WAIT_ACK: begin
        cyc_n = ~wb_ack_i;
        if (wb_ack_i) begin
          state_n = ST_IDLE;
        end
      end
      default: state_n = ST_IDLE;
    endcase
  end

  // cyc and stb come from flops so the slave ack cannot loop back
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= ST_IDLE;
      cyc_r   <= 1'b0;
    end else begin
      state_r <= state_n;
      cyc_r   <= cyc_n;
    end
  end

  assign wb_cyc_o = cyc_r;
  assign wb_stb_o = cyc_r;

  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    hold_v_i |-> (hold_addr_i[1:0] == 2'b00))
    else $error("held command address not word aligned");

  a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |-> wb_cyc_o)
    else $error("ack outside a bus cycle");

  // no abandoned bus cycles, and the request holds still until the ack
  a_cyc_until_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_cyc_o && !wb_ack_i |=> wb_cyc_o && $stable(wb_we_o) && $stable(wb_adr_o)
      && $stable(wb_sel_o) && $stable(wb_dat_o))
    else $error("bus cycle dropped or changed before ack");

endmodule

// ==== logic/mem_wb_subsystem.sv ====
// top level of the bridge: command buffer, Wishbone master, memory
// and response FIFO, with valid/ready command and response channels

`timescale 1ns/1ns

module mem_wb_subsystem (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      cmd_v_i,
  output logic                      cmd_ready_o,
  input  wb_bridge_pkg::msg_type_t  cmd_type_i,
  input  wb_bridge_pkg::msg_size_t  cmd_size_i,
  input  wb_bridge_pkg::addr_t      cmd_addr_i,
  input  wb_bridge_pkg::data_t      cmd_data_i,
  output logic                      rsp_v_o,
  input  logic                      rsp_ready_i,
  output wb_bridge_pkg::msg_type_t  rsp_type_o,
  output wb_bridge_pkg::msg_size_t  rsp_size_o,
  output wb_bridge_pkg::addr_t      rsp_addr_o,
  output wb_bridge_pkg::data_t      rsp_data_o
);

  logic                     hold_v;
  logic                     hold_consume;
  wb_bridge_pkg::msg_type_t hold_type;
  wb_bridge_pkg::msg_size_t hold_size;
  wb_bridge_pkg::addr_t     hold_addr;
  wb_bridge_pkg::data_t     hold_data;

  logic                     fifo_space;
  logic                     push;
  wb_bridge_pkg::rsp_hdr_t  push_hdr;
  wb_bridge_pkg::data_t     push_data;
  wb_bridge_pkg::rsp_hdr_t  rsp_hdr;

  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic                     wb_ack;
  wb_bridge_pkg::wb_adr_t   wb_adr;
  wb_bridge_pkg::sel_t      wb_sel;
  wb_bridge_pkg::data_t     wb_dat_m2s;
  wb_bridge_pkg::data_t     wb_dat_s2m;

  assign {rsp_type_o, rsp_size_o, rsp_addr_o} = rsp_hdr;

  cmd_holding_reg u_hold (
    .clk_i, .rst_n_i, .cmd_v_i, .cmd_ready_o,
    .cmd_type_i, .cmd_size_i, .cmd_addr_i, .cmd_data_i,
    .hold_v_o(hold_v), .hold_type_o(hold_type), .hold_size_o(hold_size),
    .hold_addr_o(hold_addr), .hold_data_o(hold_data), .hold_consume_i(hold_consume)
  );

  mem_wb_master u_master (
    .clk_i, .rst_n_i,
    .hold_v_i(hold_v), .hold_type_i(hold_type), .hold_size_i(hold_size),
    .hold_addr_i(hold_addr), .hold_data_i(hold_data), .hold_consume_o(hold_consume),
    .fifo_space_i(fifo_space), .push_o(push), .push_hdr_o(push_hdr),
    .push_data_o(push_data),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_sel_o(wb_sel), .wb_dat_o(wb_dat_m2s), .wb_dat_i(wb_dat_s2m), .wb_ack_i(wb_ack)
  );

  rsp_fifo u_rsp_fifo (
    .clk_i, .rst_n_i,
    .push_i(push), .push_hdr_i(push_hdr), .push_data_i(push_data), .space_o(fifo_space),
    .rsp_v_o, .rsp_hdr_o(rsp_hdr), .rsp_data_o, .rsp_ready_i
  );

  wb_sram u_sram (
    .clk_i, .rst_n_i,
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_sel_i(wb_sel), .wb_dat_i(wb_dat_m2s), .wb_dat_o(wb_dat_s2m), .wb_ack_o(wb_ack)
  );

endmodule

// ==== logic/rsp_fifo.sv ====
// response FIFO between the Wishbone master and the outside response channel
// push is unconditional, the writer must watch space_o; pop on valid and ready

`timescale 1ns/1ns
`include "wb_bridge_params.svh"

module rsp_fifo #(
  parameter int DEPTH = `RSP_FIFO_DEPTH
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     push_i,
  input  wb_bridge_pkg::rsp_hdr_t  push_hdr_i,
  input  wb_bridge_pkg::data_t     push_data_i,
  output logic                     space_o,
  output logic                     rsp_v_o,
  output wb_bridge_pkg::rsp_hdr_t  rsp_hdr_o,
  output wb_bridge_pkg::data_t     rsp_data_o,
  input  logic                     rsp_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  wb_bridge_pkg::rsp_hdr_t hdr_mem  [DEPTH];
  wb_bridge_pkg::data_t    data_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             pop;

  assign pop        = rsp_v_o & rsp_ready_i;
  assign rsp_v_o    = (count_r != '0);
  assign space_o    = (count_r < CNT_W'(DEPTH));
  assign rsp_hdr_o  = hdr_mem[rd_ptr_r];
  assign rsp_data_o = data_mem[rd_ptr_r];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r <= count_r + CNT_W'(push_i) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      hdr_mem[wr_ptr_r]  <= push_hdr_i;
      data_mem[wr_ptr_r] <= push_data_i;
    end
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> space_o)
    else $error("push into full response FIFO");

  // head entry must hold still under back-pressure
  a_stable_head: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_v_o && !rsp_ready_i |=> rsp_v_o && $stable(rsp_hdr_o) && $stable(rsp_data_o))
    else $error("response changed while stalled");

endmodule

// ==== logic/wb_bridge_params.svh ====
// widths and depths for the memory command to Wishbone bridge
// include wherever a size macro is needed; types are in wb_bridge_pkg

`ifndef WB_BRIDGE_PARAMS_SVH
`define WB_BRIDGE_PARAMS_SVH

// Wishbone data bus width in bits
`define WB_DATA_W 32

// byte address width of the command channel
`define WB_ADDR_W 16

// words in the Wishbone memory
`define WB_MEM_WORDS 64

// response FIFO entries
`define RSP_FIFO_DEPTH 4

`endif

// ==== logic/wb_bridge_pkg.sv ====
// shared types and encodings for the bridge, memory and testbench
// refer to members with scoped names, e.g. wb_bridge_pkg::data_t

`include "wb_bridge_params.svh"

package wb_bridge_pkg;

  // bus payload and addressing
  typedef logic [`WB_DATA_W-1:0]     data_t;
  typedef logic [`WB_ADDR_W-1:0]     addr_t;
  typedef logic [`WB_DATA_W/8-1:0]   sel_t;
  // word address, byte address without the lane bits
  typedef logic [`WB_ADDR_W-3:0]     wb_adr_t;

  // message type
  typedef logic                      msg_type_t;
  localparam msg_type_t MSG_UC_RD = 1'b0;
  localparam msg_type_t MSG_UC_WR = 1'b1;

  // log2 of the byte count, 3 behaves like SIZE_4
  typedef logic [1:0]                msg_size_t;
  localparam msg_size_t SIZE_1 = 2'd0;
  localparam msg_size_t SIZE_2 = 2'd1;
  localparam msg_size_t SIZE_4 = 2'd2;

  // response header, packed as {type, size, addr}
  typedef logic [1+2+`WB_ADDR_W-1:0] rsp_hdr_t;

endpackage

// ==== logic/wb_sram.sv ====
// Wishbone classic slave memory with byte-lane writes
// ack and read data are registered, one cycle after stb is seen

`timescale 1ns/1ns
`include "wb_bridge_params.svh"

module wb_sram (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  wb_bridge_pkg::wb_adr_t  wb_adr_i,
  input  wb_bridge_pkg::sel_t     wb_sel_i,
  input  wb_bridge_pkg::data_t    wb_dat_i,
  output wb_bridge_pkg::data_t    wb_dat_o,
  output logic                    wb_ack_o
);

  localparam int IDX_W = $clog2(`WB_MEM_WORDS);

  wb_bridge_pkg::data_t mem [`WB_MEM_WORDS];

  logic             access;
  logic [IDX_W-1:0] idx;

  // gap of one cycle between acks since the master drops stb on the ack
  assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign idx    = wb_adr_i[IDX_W-1:0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      wb_dat_o <= mem[idx];
      if (wb_we_i) begin
        for (int lane = 0; lane < `WB_DATA_W / 8; lane++) begin
          if (wb_sel_i[lane]) begin
            mem[idx][lane*8 +: 8] <= wb_dat_i[lane*8 +: 8];
          end
        end
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_mem_wb -Mdir obj_dir -o tb_mem_wb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/tb_mem_wb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1

// ==== testbench/tb_mem_wb.sv ====
// testbench for the memory command to Wishbone bridge
// fills the memory, runs directed and LFSR driven commands with back-pressure,
// and checks every response against a byte-level memory model

`timescale 1ns/1ns
`include "wb_bridge_params.svh"

module tb_mem_wb;

  localparam int N_RAND     = 300;
  localparam int N_DIRECTED = 9;
  localparam int N_CMDS     = `WB_MEM_WORDS + N_DIRECTED + `RSP_FIFO_DEPTH + 1 + N_RAND;
  localparam int CYCLE_LIMIT = 40 * N_CMDS + 200;
  localparam int EXP_W       = 3 + `WB_ADDR_W + `WB_DATA_W;
  // long enough for a bridge without back-pressure to overrun the bound
  localparam int STALL_CYCLES = 40;

  logic                     clk_i = 1'b0;
  logic                     rst_n_i;
  logic                     cmd_v_i;
  logic                     cmd_ready_o;
  wb_bridge_pkg::msg_type_t cmd_type_i;
  wb_bridge_pkg::msg_size_t cmd_size_i;
  wb_bridge_pkg::addr_t     cmd_addr_i;
  wb_bridge_pkg::data_t     cmd_data_i;
  logic                     rsp_v_o;
  logic                     rsp_ready_i = 1'b0;
  wb_bridge_pkg::msg_type_t rsp_type_o;
  wb_bridge_pkg::msg_size_t rsp_size_o;
  wb_bridge_pkg::addr_t     rsp_addr_o;
  wb_bridge_pkg::data_t     rsp_data_o;

  // 0 always ready, 1 held low, 2 random
  logic [1:0]  bp_mode = 2'd0;
  logic [31:0] lfsr_state = 32'h93a903d8;
  logic [7:0]  model_mem [4*`WB_MEM_WORDS];
  logic [EXP_W-1:0] exp_q [$];

  logic                     exp_avail = 1'b0;
  wb_bridge_pkg::msg_type_t exp_type;
  wb_bridge_pkg::msg_size_t exp_size;
  wb_bridge_pkg::addr_t     exp_addr;
  wb_bridge_pkg::data_t     exp_data;

  int cycles = 0;
  int err_mismatch = 0;
  int err_other = 0;
  int stall_cnt = 0;
  int accepted = 0;

  wb_bridge_pkg::msg_type_t rnd_type [N_RAND];
  wb_bridge_pkg::msg_size_t rnd_size [N_RAND];
  wb_bridge_pkg::addr_t     rnd_addr [N_RAND];
  wb_bridge_pkg::data_t     rnd_data [N_RAND];

  mem_wb_subsystem UUT (.*);

  always #2 clk_i = ~clk_i;

  // taps 32, 22, 2, 1; one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  // initial word pattern, depends on every address bit
  function automatic wb_bridge_pkg::data_t fill_word(input wb_bridge_pkg::addr_t a);
    return {a ^ 16'h6c1d, ~a};
  endfunction

  // apply one command to the model, return the expected response
  function automatic logic [EXP_W-1:0] model_step(input wb_bridge_pkg::msg_type_t t,
      input wb_bridge_pkg::msg_size_t s, input wb_bridge_pkg::addr_t a,
      input wb_bridge_pkg::data_t d);
    int                   base;
    int                   nbytes;
    wb_bridge_pkg::data_t rdata;
    base   = (int'(a >> 2) % `WB_MEM_WORDS) * 4;
    nbytes = (s == wb_bridge_pkg::SIZE_1) ? 1 : (s == wb_bridge_pkg::SIZE_2) ? 2 : 4;
    rdata  = '0;
    for (int lane = 0; lane < 4; lane++) begin
      if (t == wb_bridge_pkg::MSG_UC_WR) begin
        if (lane < nbytes) begin
          model_mem[base + lane] = d[lane*8 +: 8];
        end
      end else begin
        rdata[lane*8 +: 8] = model_mem[base + lane % nbytes];
      end
    end
    return {t, s, a, rdata};
  endfunction

  // called at a rising edge, returns at the edge where the command is taken
  task automatic send_cmd(input wb_bridge_pkg::msg_type_t t, input wb_bridge_pkg::msg_size_t s,
      input wb_bridge_pkg::addr_t a, input wb_bridge_pkg::data_t d);
    cmd_v_i    <= 1'b1;
    cmd_type_i <= t;
    cmd_size_i <= s;
    cmd_addr_i <= a;
    cmd_data_i <= d;
    @(negedge clk_i);
    while (!cmd_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  // keep word reads on offer for a fixed window, next address once one is taken
  task automatic offer_reads(input int n_cycles);
    int taken;
    taken = 0;
    for (int c = 0; c < n_cycles; c++) begin
      cmd_v_i    <= 1'b1;
      cmd_type_i <= wb_bridge_pkg::MSG_UC_RD;
      cmd_size_i <= wb_bridge_pkg::SIZE_4;
      cmd_addr_i <= 16'(taken * 4);
      cmd_data_i <= '0;
      @(negedge clk_i);
      if (cmd_ready_o) begin
        taken++;
      end
      @(posedge clk_i);
    end
    cmd_v_i <= 1'b0;
  endtask

  task automatic wait_drain();
    @(negedge clk_i);
    while (exp_avail || rsp_v_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  task automatic finish_run(input logic timed_out);
    $display("errors: %0d mismatches, %0d other, %0d commands accepted",
             err_mismatch, err_other, accepted);
    if (timed_out || err_mismatch != 0 || err_other != 0) begin
      $display("Test failed");
    end else begin
      $display("Test completed successfully");
    end
    $finish;
  endtask

  always @(posedge clk_i) begin
    case (bp_mode)
      2'd0:    rsp_ready_i <= 1'b1;
      2'd1:    rsp_ready_i <= 1'b0;
      default: rsp_ready_i <= (rand_bits(2) != 0);
    endcase
  end

  // handshakes are judged mid-cycle, where all signals are settled
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (rsp_v_o && rsp_ready_i && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      if (cmd_v_i && cmd_ready_o) begin
        exp_q.push_back(model_step(cmd_type_i, cmd_size_i, cmd_addr_i, cmd_data_i));
        accepted++;
        if (!rsp_ready_i) begin
          stall_cnt++;
        end
      end
      if (rsp_ready_i) begin
        stall_cnt = 0;
      end
    end
  end

  // head of the expected queue, refreshed away from the checking edge
  always @(posedge clk_i) begin
    exp_avail <= (exp_q.size() != 0);
    if (exp_q.size() != 0) begin
      {exp_type, exp_size, exp_addr, exp_data} <= exp_q[0];
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, responses still missing", cycles);
      finish_run(1'b1);
    end
  end

  a_reset_idle: assert property (@(negedge clk_i) $rose(rst_n_i) |-> !rsp_v_o && cmd_ready_o)
    else begin
      err_other++;
      $display("wrong state after reset: rsp_v_o=%b cmd_ready_o=%b", rsp_v_o, cmd_ready_o);
    end

  a_rsp_expected: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    rsp_v_o && rsp_ready_i |-> exp_avail)
    else begin
      err_other++;
      $display("response at %0t with no command waiting for it", $time);
    end

  a_rsp_type: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    rsp_v_o && rsp_ready_i && exp_avail |-> rsp_type_o == exp_type)
    else begin
      err_mismatch++;
      $display("Mismatch at %0t: rsp_type_o got %h expected %h", $time, rsp_type_o, exp_type);
    end

  a_rsp_size: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    rsp_v_o && rsp_ready_i && exp_avail |-> rsp_size_o == exp_size)
    else begin
      err_mismatch++;
      $display("Mismatch at %0t: rsp_size_o got %h expected %h", $time, rsp_size_o, exp_size);
    end

  a_rsp_addr: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    rsp_v_o && rsp_ready_i && exp_avail |-> rsp_addr_o == exp_addr)
    else begin
      err_mismatch++;
      $display("Mismatch at %0t: rsp_addr_o got %h expected %h", $time, rsp_addr_o, exp_addr);
    end

  a_rsp_data: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    rsp_v_o && rsp_ready_i && exp_avail |-> rsp_data_o == exp_data)
    else begin
      err_mismatch++;
      $display("Mismatch at %0t: rsp_data_o got %h expected %h", $time, rsp_data_o, exp_data);
    end

  // FIFO entries plus the holding register bound what a stalled bridge takes
  a_stall_bound: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    stall_cnt <= `RSP_FIFO_DEPTH + 2)
    else begin
      err_other++;
      $display("bridge took %0d commands while responses were stalled", stall_cnt);
    end

  initial begin
    rst_n_i    = 1'b0;
    cmd_v_i    = 1'b0;
    cmd_type_i = wb_bridge_pkg::MSG_UC_RD;
    cmd_size_i = wb_bridge_pkg::SIZE_1;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    for (int i = 0; i < N_RAND; i++) begin
      rnd_type[i] = wb_bridge_pkg::msg_type_t'(rand_bits(1));
      rnd_size[i] = wb_bridge_pkg::msg_size_t'(rand_bits(2));
      rnd_addr[i] = {4'b0000, 10'(rand_bits(10)), 2'b00};
      rnd_data[i] = rand_bits(32);
    end
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    for (int w = 0; w < `WB_MEM_WORDS; w++) begin
      send_cmd(wb_bridge_pkg::MSG_UC_WR, wb_bridge_pkg::SIZE_4, 16'(w * 4), fill_word(16'(w * 4)));
    end

    // full word, byte and halfword traffic, 0x0124 aliases word 9
    send_cmd(wb_bridge_pkg::MSG_UC_WR, wb_bridge_pkg::SIZE_4, 16'h0014, 32'hdeadbeef);
    send_cmd(wb_bridge_pkg::MSG_UC_RD, wb_bridge_pkg::SIZE_4, 16'h0014, 32'h0);
    send_cmd(wb_bridge_pkg::MSG_UC_WR, wb_bridge_pkg::SIZE_1, 16'h0020, 32'h123456c3);
    send_cmd(wb_bridge_pkg::MSG_UC_RD, wb_bridge_pkg::SIZE_4, 16'h0020, 32'h0);
    send_cmd(wb_bridge_pkg::MSG_UC_RD, wb_bridge_pkg::SIZE_1, 16'h0020, 32'h0);
    send_cmd(wb_bridge_pkg::MSG_UC_WR, wb_bridge_pkg::SIZE_2, 16'h0124, 32'h9876a55a);
    send_cmd(wb_bridge_pkg::MSG_UC_RD, wb_bridge_pkg::SIZE_2, 16'h0024, 32'h0);
    send_cmd(wb_bridge_pkg::MSG_UC_RD, wb_bridge_pkg::SIZE_4, 16'h0124, 32'h0);
    send_cmd(wb_bridge_pkg::MSG_UC_RD, 2'd3, 16'h0014, 32'h0);
    cmd_v_i <= 1'b0;
    wait_drain();

    // stall the response side until the bridge pushes back
    bp_mode <= 2'd1;
    repeat (2) @(posedge clk_i);
    offer_reads(STALL_CYCLES);
    @(negedge clk_i);
    assert (!cmd_ready_o) else begin
      err_other++;
      $display("cmd_ready_o still high with the response FIFO full");
    end
    @(posedge clk_i);
    bp_mode <= 2'd0;
    wait_drain();

    bp_mode <= 2'd2;
    for (int i = 0; i < N_RAND; i++) begin
      send_cmd(rnd_type[i], rnd_size[i], rnd_addr[i], rnd_data[i]);
    end
    cmd_v_i <= 1'b0;
    bp_mode <= 2'd0;
    wait_drain();
    repeat (4) @(negedge clk_i);
    assert (!rsp_v_o && exp_q.size() == 0) else begin
      err_other++;
      $display("responses left over at the end of the run");
    end
    finish_run(1'b0);
  end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/wb_bridge_pkg.sv
logic/cmd_holding_reg.sv
logic/rsp_fifo.sv
logic/mem_wb_master.sv
logic/wb_sram.sv
logic/mem_wb_subsystem.sv
testbench/tb_mem_wb.sv
